// ==== source/cache_types_pkg.sv ====
package cache_types_pkg;

    // ================================================
    // line geometry
    // ================================================
    localparam int s_offset = 5;                 // byte offset within a line
    localparam int s_mask   = 2**s_offset;       // bytes per line
    localparam int s_line   = 8 * s_mask;        // bits per line

    // ================================================
    // cpu word
    // ================================================
    localparam int s_word   = 32;
    localparam int s_words  = s_line / s_word;   // words per line
    localparam int s_woff   = $clog2(s_words);   // word select bits

    // one full cacheline as seen on the pmem side
    typedef logic [s_line-1:0] line_t;

    // one enable per byte of a line
    typedef logic [s_mask-1:0] line_mask_t;

    typedef logic [s_word-1:0] word_t;

    // cpu byte enables
    typedef logic [s_word/8-1:0] be_t;

endpackage : cache_types_pkg

// ==== source/cache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

    // ================================================
    // miss fsm
    // ================================================
    typedef enum logic [2:0] {
        idle,
        compare,         // tag check, hit answers here
        writeback,       // dirty victim out to pmem
        fill,            // line in from pmem
        done
    } cache_state_e;

    // ================================================
    // control <-> datapath
    // ================================================
    typedef struct packed {
        logic way_sel;           // way being written
        logic data_from_mem;     // fill vs cpu write
        logic data_load;
        logic tag_load;
        logic valid_load;
        logic dirty_load;
        logic dirty_in;
        logic lru_load;
        logic lru_in;
        logic addr_from_victim;  // pmem address from victim tag
    } dp_ctrl_t;

    typedef struct packed {
        logic [1:0] hit;         // per way
        logic       victim_dirty;
        logic       victim_way;  // lru pick
    } dp_status_t;

endpackage : cache_ctrl_pkg

// ==== source/cache_array.sv ====
module cache_array import cache_types_pkg::*; #(
    parameter type t_payload = line_t,
    parameter int  s_index   = 3,
    localparam int s_bytes   = ($bits(t_payload) + 7) / 8
) (
    input  logic               clk,
    input  logic               load,
    input  logic [s_bytes-1:0] wmask,
    input  logic [s_index-1:0] index,
    input  t_payload           wdata,
    output t_payload           rdata
);

    localparam int num_sets = 2**s_index;
    localparam int s_width  = $bits(t_payload);

    t_payload           mem [num_sets];
    logic [s_width-1:0] bit_en;
    logic [s_width-1:0] merged;

    // byte enables spread to bits, top byte may be partial
    always_comb begin
        for (int i = 0; i < s_width; i++) begin
            bit_en[i] = wmask[i / 8];
        end
    end

    assign merged = (mem[index] & ~bit_en) | (wdata & bit_en);

    always_ff @(posedge clk) begin
        if (load) begin
            mem[index] <= t_payload'(merged);
        end
    end

    assign rdata = mem[index];   // async read

endmodule : cache_array

// ==== source/cache_datapath.sv ====
module cache_datapath import cache_types_pkg::*, cache_ctrl_pkg::*; #(
    parameter int s_index = 3
) (
    input  logic       clk,
    input  logic       rst_n,
    input  dp_ctrl_t   ctrl,
    output dp_status_t status,
    input  word_t      mem_address,
    input  word_t      mem_wdata,
    input  be_t        mem_byte_enable,
    output word_t      mem_rdata,
    input  line_t      pmem_rdata,
    output line_t      pmem_wdata,
    output word_t      pmem_address
);

    localparam int s_tag    = s_word - s_offset - s_index;
    localparam int num_sets = 2**s_index;

    typedef logic [s_tag-1:0] tag_t;

    // ================================================
    // address split
    // ================================================
    tag_t               tag;
    logic [s_index-1:0] index;
    logic [s_woff-1:0]  word_off;

    assign tag      = mem_address[s_word-1 -: s_tag];
    assign index    = mem_address[s_offset +: s_index];
    assign word_off = mem_address[2 +: s_woff];

    // ================================================
    // valid, dirty, lru
    // ================================================
    logic [1:0][num_sets-1:0] valid_q;
    logic [1:0][num_sets-1:0] dirty_q;
    logic [num_sets-1:0]      lru_q;    // points at way to replace

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (ctrl.valid_load)
                valid_q[ctrl.way_sel][index] <= 1'b1;
            if (ctrl.dirty_load)
                dirty_q[ctrl.way_sel][index] <= ctrl.dirty_in;
            if (ctrl.lru_load)
                lru_q[index] <= ctrl.lru_in;
        end
    end

    // ================================================
    // write data and byte mask
    // ================================================
    line_t      cpu_line;
    line_mask_t cpu_mask;
    line_t      data_in;
    line_mask_t data_mask;

    assign cpu_line  = {s_words{mem_wdata}};
    assign cpu_mask  = line_mask_t'(mem_byte_enable) << (word_off * (s_word / 8));
    assign data_in   = ctrl.data_from_mem ? pmem_rdata : cpu_line;
    assign data_mask = ctrl.data_from_mem ? '1 : cpu_mask;   // fill writes whole line

    // ================================================
    // arrays
    // ================================================
    logic  data_load0, data_load1;
    logic  tag_load0, tag_load1;
    line_t line_rd0, line_rd1;
    tag_t  tag_rd0, tag_rd1;

    assign data_load0 = ctrl.data_load && !ctrl.way_sel;
    assign data_load1 = ctrl.data_load && ctrl.way_sel;
    assign tag_load0  = ctrl.tag_load && !ctrl.way_sel;
    assign tag_load1  = ctrl.tag_load && ctrl.way_sel;

    cache_array #(.t_payload(line_t), .s_index(s_index)) data0 (
        .clk,
        .load  (data_load0),
        .wmask (data_mask),
        .index,
        .wdata (data_in),
        .rdata (line_rd0)
    );

    cache_array #(.t_payload(line_t), .s_index(s_index)) data1 (
        .clk,
        .load  (data_load1),
        .wmask (data_mask),
        .index,
        .wdata (data_in),
        .rdata (line_rd1)
    );

    cache_array #(.t_payload(tag_t), .s_index(s_index)) tag0 (
        .clk,
        .load  (tag_load0),
        .wmask ('1),
        .index,
        .wdata (tag),
        .rdata (tag_rd0)
    );

    cache_array #(.t_payload(tag_t), .s_index(s_index)) tag1 (
        .clk,
        .load  (tag_load1),
        .wmask ('1),
        .index,
        .wdata (tag),
        .rdata (tag_rd1)
    );

    // ================================================
    // compare, victim, outputs
    // ================================================
    logic [1:0] hit;
    logic       victim_way;
    line_t      hit_line;
    tag_t       victim_tag;
    tag_t       pmem_tag;

    assign hit[0]     = valid_q[0][index] && (tag_rd0 == tag);
    assign hit[1]     = valid_q[1][index] && (tag_rd1 == tag);
    assign victim_way = lru_q[index];

    assign status.hit          = hit;
    assign status.victim_way   = victim_way;
    assign status.victim_dirty = valid_q[victim_way][index] && dirty_q[victim_way][index];

    assign hit_line  = hit[1] ? line_rd1 : line_rd0;
    assign mem_rdata = hit_line[word_off * s_word +: s_word];

    assign victim_tag   = victim_way ? tag_rd1 : tag_rd0;
    assign pmem_tag     = ctrl.addr_from_victim ? victim_tag : tag;
    assign pmem_address = {pmem_tag, index, {s_offset{1'b0}}};   // line aligned
    assign pmem_wdata   = victim_way ? line_rd1 : line_rd0;

endmodule : cache_datapath

// ==== source/cache_control.sv ====
module cache_control import cache_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       mem_read,
    input  logic       mem_write,
    input  logic       pmem_resp,
    input  dp_status_t status,
    output dp_ctrl_t   ctrl,
    output logic       mem_resp,
    output logic       pmem_read,
    output logic       pmem_write
);

    cache_state_e state;
    cache_state_e state_next;
    logic         hit;
    logic         hit_way;

    assign hit     = |status.hit;
    assign hit_way = status.hit[1];

    // ================================================
    // state register
    // ================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    // ================================================
    // next state
    // ================================================
    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (mem_read || mem_write)
                    state_next = compare;
            end
            compare: begin
                if (hit)
                    state_next = done;
                else if (status.victim_dirty)
                    state_next = writeback;
                else
                    state_next = fill;
            end
            writeback: begin
                if (pmem_resp)
                    state_next = fill;
            end
            fill: begin
                if (pmem_resp)
                    state_next = compare;   // retry, now hits
            end
            done: begin
                state_next = idle;          // cpu drops request here
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    // ================================================
    // outputs and load strobes
    // ================================================
    always_comb begin
        ctrl         = '0;
        ctrl.way_sel = status.victim_way;
        mem_resp     = 1'b0;
        pmem_read    = 1'b0;
        pmem_write   = 1'b0;
        case (state)
            compare: begin
                if (hit) begin
                    mem_resp      = 1'b1;
                    ctrl.way_sel  = hit_way;
                    ctrl.lru_load = 1'b1;
                    ctrl.lru_in   = ~hit_way;   // other way becomes lru
                    if (mem_write) begin
                        ctrl.data_load  = 1'b1;
                        ctrl.dirty_load = 1'b1;
                        ctrl.dirty_in   = 1'b1;
                    end
                end
            end
            writeback: begin
                pmem_write            = 1'b1;
                ctrl.addr_from_victim = 1'b1;
            end
            fill: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    ctrl.data_from_mem = 1'b1;
                    ctrl.data_load     = 1'b1;
                    ctrl.tag_load      = 1'b1;
                    ctrl.valid_load    = 1'b1;
                    ctrl.dirty_load    = 1'b1;   // clean after fill
                    ctrl.dirty_in      = 1'b0;
                end
            end
            default: begin
            end
        endcase
    end

endmodule : cache_control

// ==== source/cache.sv ====
module cache import cache_types_pkg::*, cache_ctrl_pkg::*; #(
    parameter int s_index = 3
) (
    input  logic  clk,
    input  logic  rst_n,
    // cpu side
    input  logic  mem_read,
    input  logic  mem_write,
    input  be_t   mem_byte_enable,
    input  word_t mem_address,
    input  word_t mem_wdata,
    output word_t mem_rdata,
    output logic  mem_resp,
    // pmem side
    input  line_t pmem_rdata,
    output line_t pmem_wdata,
    output word_t pmem_address,
    output logic  pmem_read,
    output logic  pmem_write,
    input  logic  pmem_resp
);

    dp_ctrl_t   ctrl;
    dp_status_t status;

    cache_control control0 (
        .clk,
        .rst_n,
        .mem_read,
        .mem_write,
        .pmem_resp,
        .status,
        .ctrl,
        .mem_resp,
        .pmem_read,
        .pmem_write
    );

    cache_datapath #(.s_index(s_index)) datapath0 (
        .clk,
        .rst_n,
        .ctrl,
        .status,
        .mem_address,
        .mem_wdata,
        .mem_byte_enable,
        .mem_rdata,
        .pmem_rdata,
        .pmem_wdata,
        .pmem_address
    );

endmodule : cache

// ==== verif/cache_assertions.sv ====
module cache_assertions import cache_types_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  mem_resp,
    input logic  pmem_read,
    input logic  pmem_write,
    input logic  pmem_resp,
    input word_t pmem_address
);

    timeunit 1ns;
    timeprecision 100ps;

    resp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mem_resp |=> !mem_resp)
        else $error("mem_resp high for more than one cycle");

    pmem_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(pmem_read && pmem_write))
        else $error("pmem_read and pmem_write high together");

    // address steady while a request waits
    addr_held: assert property (@(posedge clk) disable iff (!rst_n)
        ((pmem_read || pmem_write) && !pmem_resp) |=> $stable(pmem_address))
        else $error("pmem_address changed before pmem_resp");

    read_held: assert property (@(posedge clk) disable iff (!rst_n)
        (pmem_read && !pmem_resp) |=> pmem_read)
        else $error("pmem_read dropped before pmem_resp");

    write_held: assert property (@(posedge clk) disable iff (!rst_n)
        (pmem_write && !pmem_resp) |=> pmem_write)
        else $error("pmem_write dropped before pmem_resp");

endmodule : cache_assertions

bind cache cache_assertions assertions0 (
    .clk,
    .rst_n,
    .mem_resp,
    .pmem_read,
    .pmem_write,
    .pmem_resp,
    .pmem_address
);

// ==== verif/cache_tb.sv ====
module cache_tb import cache_types_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int s_index    = 3;
    localparam int max_delay  = 3;                 // pmem answers after 0 to 3 cycles
    localparam int num_random = 400;
    localparam int num_ops    = num_random + 16;   // directed ops and reset margin

    localparam word_t addr_a = 32'h0001_0020;      // a, b, c share set 1
    localparam word_t addr_b = 32'h0002_0024;
    localparam word_t addr_c = 32'h0003_0028;
    localparam logic [23:0] tag_pool [4] = '{24'h000100, 24'h00a5c3, 24'h7f0012, 24'hc31e07};

    logic  clk             = 1'b0;
    logic  rst_n           = 1'b0;
    logic  mem_read        = 1'b0;
    logic  mem_write       = 1'b0;
    be_t   mem_byte_enable = '0;
    word_t mem_address     = '0;
    word_t mem_wdata       = '0;
    line_t pmem_rdata      = '0;
    logic  pmem_resp       = 1'b0;
    word_t mem_rdata;
    logic  mem_resp;
    line_t pmem_wdata;
    word_t pmem_address;
    logic  pmem_read;
    logic  pmem_write;

    integer     seed        = 32'h5199d6a2;
    int         reads_seen  = 0;
    int         writes_seen = 0;
    int         latency;
    logic [7:0] ref_mem  [word_t];   // expected bytes as the cpu sees them
    line_t      pmem_mem [word_t];   // backing store by line address

    cache #(.s_index(s_index)) dut0 (.*);

    always #20 clk = ~clk;

    // ================================================
    // memory models
    // ================================================
    function automatic logic [7:0] fill_byte(word_t addr);
        word_t h;
        h = addr * 32'h9e3779b1;
        return h[31:24] ^ h[7:0];
    endfunction

    function automatic logic [7:0] ref_byte(word_t addr);
        return ref_mem.exists(addr) ? ref_mem[addr] : fill_byte(addr);
    endfunction

    function automatic word_t ref_word(word_t addr);
        word_t w;
        for (int i = 0; i < 4; i++)
            w[8*i +: 8] = ref_byte({addr[31:2], 2'b00} + i);
        return w;
    endfunction

    function automatic line_t ref_line(word_t line_addr);
        line_t l;
        for (int i = 0; i < s_mask; i++)
            l[8*i +: 8] = ref_byte(line_addr + i);
        return l;
    endfunction

    function automatic line_t stored_line(word_t line_addr);
        line_t l;
        if (pmem_mem.exists(line_addr))
            return pmem_mem[line_addr];
        for (int i = 0; i < s_mask; i++)
            l[8*i +: 8] = fill_byte(line_addr + i);
        return l;
    endfunction

    task automatic check_value(string name, logic [255:0] got, logic [255:0] expected);
        if (got !== expected) begin
            $display("FAIL %s got=%h exp=%h", name, got, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // ================================================
    // cpu side
    // ================================================
    task automatic access(logic write, word_t addr, word_t wdata, be_t be);
        word_t expected;
        word_t base;
        int    reads_before;
        expected     = ref_word(addr);
        base         = {addr[31:2], 2'b00};
        reads_before = reads_seen;
        @(posedge clk);
        mem_read        <= !write;
        mem_write       <= write;
        mem_address     <= addr;
        mem_wdata       <= wdata;
        mem_byte_enable <= be;
        @(negedge clk);
        latency = 0;
        while (!mem_resp) begin
            @(negedge clk);
            latency++;
        end
        if (!write)
            check_value("mem_rdata", 256'(mem_rdata), 256'(expected));
        if (reads_before == reads_seen)
            check_value("hit latency", 256'(latency), 256'(1));   // hit answers next cycle
        for (int i = 0; i < 4; i++) begin
            if (write && be[i])
                ref_mem[base + i] = wdata[8*i +: 8];
        end
        @(posedge clk);
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
    endtask

    task automatic read_expect(word_t addr, int fills);
        int reads_before;
        int writes_before;
        reads_before  = reads_seen;
        writes_before = writes_seen;
        access(1'b0, addr, '0, '0);
        check_value("pmem_read count", 256'(reads_seen - reads_before), 256'(fills));
        check_value("pmem_write count", 256'(writes_seen - writes_before), 256'(0));
    endtask

    // ================================================
    // pmem responder
    // ================================================
    initial begin
        word_t r;
        int    delay;
        forever begin
            @(negedge clk);
            if (pmem_read || pmem_write) begin
                r     = $random(seed);
                delay = int'(r[1:0]);
                repeat (delay) @(negedge clk);
                if (pmem_write) begin
                    check_value("pmem_wdata", pmem_wdata, ref_line(pmem_address));
                    pmem_mem[pmem_address] = pmem_wdata;
                    writes_seen++;
                end else begin
                    reads_seen++;
                end
                @(posedge clk);
                pmem_resp  <= 1'b1;
                pmem_rdata <= stored_line(pmem_address);
                @(posedge clk);
                pmem_resp  <= 1'b0;
            end
        end
    end

    initial begin
        #(num_ops * (4 * max_delay + 10) * 40);
        $display("ERROR: timed out, the cache never answered a request");
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    // ================================================
    // test sequence
    // ================================================
    initial begin
        word_t r;
        word_t addr;
        word_t wdata;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("mem_resp", 256'(mem_resp), 256'(0));
        check_value("pmem_read", 256'(pmem_read), 256'(0));
        check_value("pmem_write", 256'(pmem_write), 256'(0));

        read_expect(addr_a, 1);
        read_expect(addr_b, 1);
        read_expect(addr_a, 0);
        read_expect(addr_c, 1);        // b is lru, clean
        read_expect(addr_a, 0);
        read_expect(addr_b, 1);

        // three tags rotating through set 2, all clean misses
        read_expect(32'h0001_0040, 1);
        read_expect(32'h0002_0040, 1);
        read_expect(32'h0003_0040, 1);
        read_expect(32'h0001_0040, 1);

        for (int n = 0; n < num_random; n++) begin
            r     = $random(seed);
            wdata = $random(seed);
            addr  = {tag_pool[r[1:0]], 1'b0, r[3:2], r[6:4], 2'b00};   // sets 0 to 3
            access(r[7], addr, wdata, r[11:8]);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule : cache_tb

// ==== cache.f ====
source/cache_types_pkg.sv
source/cache_ctrl_pkg.sv
source/cache_array.sv
source/cache_datapath.sv
source/cache_control.sv
source/cache.sv
verif/cache_assertions.sv
verif/cache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    --top-module cache_tb \
    --Mdir obj_dir \
    -o cache_sim \
    -f cache.f

./obj_dir/cache_sim
